/* all.f */
+incdir+logic
logic/csr_pkg.sv
logic/exu_csr_unit.sv
logic/csr_regfile.sv
logic/csr_subsys_top.sv
tb/tb_csr_subsys.sv

/* logic/csr_cfg.svh */
// CSR slice configuration
// data and address widths, CSR addresses and reset values

`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// widths
`define XLEN         32
`define CSR_ADDR_W   12
`define REG_ADDR_W   5
`define COMMIT_ID_W  3

// fcsr field widths
`define FFLAGS_W     5
`define FRM_W        3
`define FCSR_RSVD_W  24

// implemented CSR addresses
`define CSR_FFLAGS   12'h001
`define CSR_FRM      12'h002
`define CSR_FCSR     12'h003
`define CSR_MTVEC    12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCYCLE   12'hB00

// only mtvec has a non-zero reset value
`define MTVEC_RESET  32'h0000_0100

`endif

/* logic/csr_pkg.sv */
// CSR slice types
// issue request, GPR result, CSR write and the fcsr layout

`include "csr_cfg.svh"

package csr_pkg;

    // read-modify-write rule, encoded as funct3[1:0]
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_e;

    // one issued CSR instruction
    typedef struct packed {
        csr_op_e                  op;
        logic [`CSR_ADDR_W-1:0]   addr;
        logic [`XLEN-1:0]         op1;        // rs1 value or decoded immediate
        logic [`REG_ADDR_W-1:0]   rd;
        logic [`COMMIT_ID_W-1:0]  commit_id;
        logic                     csr_we;     // low for RS/RC with rs1 = x0
        logic                     reg_we;     // low for rd = x0
    } csr_req_t;

    // one CSR write towards the register file
    typedef struct packed {
        logic                     we;
        logic [`CSR_ADDR_W-1:0]   addr;
        logic [`XLEN-1:0]         wdata;
    } csr_wr_t;

    // GPR writeback result
    typedef struct packed {
        logic                     reg_we;
        logic [`REG_ADDR_W-1:0]   rd;
        logic [`XLEN-1:0]         wdata;
        logic [`COMMIT_ID_W-1:0]  commit_id;
    } csr_res_t;

    // fcsr split into its two architectural fields
    typedef struct packed {
        logic [`FCSR_RSVD_W-1:0]  rsvd;       // reads zero
        logic [`FRM_W-1:0]        frm;
        logic [`FFLAGS_W-1:0]     fflags;
    } fcsr_fields_t;

    // same stored word seen raw or by field
    typedef union packed {
        logic [`XLEN-1:0]         raw;
        fcsr_fields_t             fld;
    } fcsr_u;

endpackage

/* logic/csr_regfile.sv */
// CSR register file
// machine CSRs, free-running mcycle and fcsr with FPU flag accumulation

`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_regfile (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic [`CSR_ADDR_W-1:0] rd_addr_i,
    input  csr_pkg::csr_wr_t       csr_wr_i,
    input  logic                   fp_flags_valid_i,
    input  logic [`FFLAGS_W-1:0]   fp_flags_i,       // sticky exception flags
    output logic [`XLEN-1:0]       rd_data_o
);
    import csr_pkg::*;

    logic [`XLEN-1:0] mtvec_q;
    logic [`XLEN-1:0] mscratch_q;
    logic [`XLEN-1:0] mepc_q;
    logic [`XLEN-1:0] mcycle_q;
    fcsr_u            fcsr_q;
    fcsr_u            fcsr_nxt;

    logic             wr_mtvec;
    logic             wr_mscratch;
    logic             wr_mepc;
    logic             wr_mcycle;

    // write decode
    assign wr_mtvec    = csr_wr_i.we & (csr_wr_i.addr == `CSR_MTVEC);
    assign wr_mscratch = csr_wr_i.we & (csr_wr_i.addr == `CSR_MSCRATCH);
    assign wr_mepc     = csr_wr_i.we & (csr_wr_i.addr == `CSR_MEPC);
    assign wr_mcycle   = csr_wr_i.we & (csr_wr_i.addr == `CSR_MCYCLE);

    // read mux
    always_comb begin
        case (rd_addr_i)
            `CSR_FFLAGS:   rd_data_o = {{(`XLEN-`FFLAGS_W){1'b0}}, fcsr_q.fld.fflags};
            `CSR_FRM:      rd_data_o = {{(`XLEN-`FRM_W){1'b0}}, fcsr_q.fld.frm};
            `CSR_FCSR:     rd_data_o = fcsr_q.raw;
            `CSR_MTVEC:    rd_data_o = mtvec_q;
            `CSR_MSCRATCH: rd_data_o = mscratch_q;
            `CSR_MEPC:     rd_data_o = mepc_q;
            `CSR_MCYCLE:   rd_data_o = mcycle_q;
            default:       rd_data_o = '0;   // unimplemented
        endcase
    end

    // software write first, then FPU flags on top
    always_comb begin
        fcsr_nxt = fcsr_q;
        if (csr_wr_i.we) begin
            case (csr_wr_i.addr)
                `CSR_FFLAGS: fcsr_nxt.fld.fflags = csr_wr_i.wdata[`FFLAGS_W-1:0];
                `CSR_FRM:    fcsr_nxt.fld.frm    = csr_wr_i.wdata[`FRM_W-1:0];
                `CSR_FCSR: begin
                    // only frm and fflags exist
                    fcsr_nxt.raw = {{`FCSR_RSVD_W{1'b0}},
                                    csr_wr_i.wdata[`FRM_W+`FFLAGS_W-1:0]};
                end
                default: ;
            endcase
        end
        if (fp_flags_valid_i)
            fcsr_nxt.fld.fflags = fcsr_nxt.fld.fflags | fp_flags_i;   // accrue
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mtvec_q    <= `MTVEC_RESET;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcycle_q   <= '0;
            fcsr_q     <= '0;
        end else begin
            if (wr_mtvec)    mtvec_q    <= csr_wr_i.wdata;
            if (wr_mscratch) mscratch_q <= csr_wr_i.wdata;
            if (wr_mepc)     mepc_q     <= csr_wr_i.wdata;
            // counts every edge unless software loads it
            if (wr_mcycle)
                mcycle_q <= csr_wr_i.wdata;
            else
                mcycle_q <= mcycle_q + 1'b1;
            fcsr_q <= fcsr_nxt;
        end
    end

    // reserved fcsr bits never get set by any path
    a_fcsr_rsvd: assert property (@(posedge clk) disable iff (rst_i)
        fcsr_q.fld.rsvd == '0);

endmodule

/* logic/csr_subsys_top.sv */
// CSR subsystem top
// execute unit feeding the CSR register file

`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_subsys_top (
    input  logic                 clk,
    input  logic                 rst_i,
    // issue side
    input  logic                 req_valid_i,
    input  csr_pkg::csr_req_t    req_i,
    output logic                 stall_o,
    input  logic                 int_assert_i,
    // FPU side
    input  logic                 fflags_pending_i,
    input  logic                 fp_flags_valid_i,
    input  logic [`FFLAGS_W-1:0] fp_flags_i,
    // writeback side
    output csr_pkg::csr_res_t    res_o,
    input  logic                 wb_ready_i
);
    import csr_pkg::*;

    logic [`CSR_ADDR_W-1:0] rd_addr;   // combinational read port
    logic [`XLEN-1:0]       rd_data;
    csr_wr_t                csr_wr;    // one-shot write from the output stage

    exu_csr_unit u_exu_csr_unit (
        .clk              (clk),
        .rst_i            (rst_i),
        .req_valid_i      (req_valid_i),
        .req_i            (req_i),
        .rd_data_i        (rd_data),
        .int_assert_i     (int_assert_i),
        .fflags_pending_i (fflags_pending_i),
        .wb_ready_i       (wb_ready_i),
        .rd_addr_o        (rd_addr),
        .stall_o          (stall_o),
        .csr_wr_o         (csr_wr),
        .res_o            (res_o)
    );

    csr_regfile u_csr_regfile (
        .clk              (clk),
        .rst_i            (rst_i),
        .rd_addr_i        (rd_addr),
        .csr_wr_i         (csr_wr),
        .fp_flags_valid_i (fp_flags_valid_i),
        .fp_flags_i       (fp_flags_i),
        .rd_data_o        (rd_data)
    );

endmodule

/* logic/exu_csr_unit.sv */
// CSR execute unit
// read-modify-write with forwarding, kill and stall, one-deep output stage

`timescale 1ns/1ps
`include "csr_cfg.svh"

module exu_csr_unit (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   req_valid_i,
    input  csr_pkg::csr_req_t      req_i,
    input  logic [`XLEN-1:0]       rd_data_i,        // regfile read of rd_addr_o
    input  logic                   int_assert_i,     // kills the current request
    input  logic                   fflags_pending_i, // FPU flags still in flight
    input  logic                   wb_ready_i,
    output logic [`CSR_ADDR_W-1:0] rd_addr_o,
    output logic                   stall_o,
    output csr_pkg::csr_wr_t       csr_wr_o,
    output csr_pkg::csr_res_t      res_o
);
    import csr_pkg::*;

    logic                    valid_op;   // request not killed
    logic                    fp_access;  // touches fflags/frm/fcsr
    logic                    load_en;    // output stage may take a new item
    logic                    take;       // instruction accepted this edge
    logic [`XLEN-1:0]        old_val;
    logic [`XLEN-1:0]        new_val;

    // control flops
    logic                    res_we_q;
    logic                    wr_we_q;
    // payload flops
    logic [`REG_ADDR_W-1:0]  res_rd_q;
    logic [`XLEN-1:0]        res_wdata_q;
    logic [`COMMIT_ID_W-1:0] res_cid_q;
    logic [`CSR_ADDR_W-1:0]  wr_addr_q;
    logic [`XLEN-1:0]        wr_wdata_q;

    // view of a read address after a pending write, fcsr aliases included
    function automatic logic [`XLEN-1:0] fwd_view(
        input logic [`CSR_ADDR_W-1:0] waddr,
        input logic [`XLEN-1:0]       wdata,
        input logic [`CSR_ADDR_W-1:0] raddr,
        input logic [`XLEN-1:0]       cur
    );
        logic [`XLEN-1:0] v;
        v = cur;
        case (raddr)
            `CSR_FFLAGS: begin
                if (waddr == `CSR_FFLAGS || waddr == `CSR_FCSR)
                    v = {{(`XLEN-5){1'b0}}, wdata[4:0]};
            end
            `CSR_FRM: begin
                if (waddr == `CSR_FRM)
                    v = {{(`XLEN-3){1'b0}}, wdata[2:0]};
                else if (waddr == `CSR_FCSR)
                    v = {{(`XLEN-3){1'b0}}, wdata[7:5]};   // frm sits above fflags
            end
            `CSR_FCSR: begin
                if (waddr == `CSR_FCSR)
                    v = {{(`XLEN-8){1'b0}}, wdata[7:0]};
                else if (waddr == `CSR_FFLAGS)
                    v = {{(`XLEN-8){1'b0}}, cur[7:5], wdata[4:0]};
                else if (waddr == `CSR_FRM)
                    v = {{(`XLEN-8){1'b0}}, wdata[2:0], cur[4:0]};
            end
            `CSR_MTVEC, `CSR_MSCRATCH, `CSR_MEPC, `CSR_MCYCLE: begin
                if (waddr == raddr) v = wdata;
            end
            default: ;  // unimplemented reads stay zero
        endcase
        return v;
    endfunction

    assign rd_addr_o = req_i.addr;

    assign valid_op  = req_valid_i & ~int_assert_i;
    assign fp_access = valid_op & ((req_i.addr == `CSR_FFLAGS) | (req_i.addr == `CSR_FRM) |
                                   (req_i.addr == `CSR_FCSR));
    assign load_en   = wb_ready_i | ~res_we_q;

    // held result with a waiting request, or FP CSR access behind pending flags
    assign stall_o = (valid_op & res_we_q & ~wb_ready_i) | (fp_access & fflags_pending_i);
    assign take    = valid_op & ~stall_o;     // implies load_en

    // old value, forwarded when the write stage still holds a write
    always_comb begin
        old_val = rd_data_i;
        if (wr_we_q)
            old_val = fwd_view(wr_addr_q, wr_wdata_q, req_i.addr, rd_data_i);
    end

    always_comb begin
        case (req_i.op)
            CSR_RW:  new_val = req_i.op1;
            CSR_RS:  new_val = old_val | req_i.op1;
            CSR_RC:  new_val = old_val & ~req_i.op1;
            default: new_val = old_val;        // no change
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            res_we_q <= 1'b0;
            wr_we_q  <= 1'b0;
        end else begin
            if (load_en) res_we_q <= take & req_i.reg_we;
            wr_we_q <= take & req_i.csr_we;    // drops right after its commit edge
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            res_rd_q    <= req_i.rd;
            res_cid_q   <= req_i.commit_id;
            res_wdata_q <= take ? old_val : '0;   // killed or idle gives zero
            wr_addr_q   <= req_i.addr;
            wr_wdata_q  <= take ? new_val : '0;
        end
    end

    assign res_o    = '{reg_we: res_we_q, rd: res_rd_q, wdata: res_wdata_q,
                        commit_id: res_cid_q};
    assign csr_wr_o = '{we: wr_we_q, addr: wr_addr_q, wdata: wr_wdata_q};

    // writeback sees a frozen result until it takes it
    a_res_held: assert property (@(posedge clk) disable iff (rst_i)
        (res_o.reg_we && !wb_ready_i) |=> $stable(res_o));

    // a stalled request stays on the issue port until it is taken
    a_stall_req: assert property (@(posedge clk) disable iff (rst_i)
        stall_o |=> (req_valid_i && $stable(req_i)));

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the CSR subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -f all.f \
    --top-module tb_csr_subsys --Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* tb/tb_csr_subsys.sv */
// CSR subsystem testbench
// directed tests checked against a shadow CSR model

`timescale 1ns/1ps
`include "csr_cfg.svh"

module tb_csr_subsys;
    import csr_pkg::*;

    localparam int NUM_TESTS = 6;

    logic                    clk = 1'b0;
    logic                    rst_i = 1'b1;
    logic                    req_valid_i = 1'b0;
    csr_req_t                req_i = '0;
    logic                    stall_o;
    logic                    int_assert_i = 1'b0;
    logic                    fflags_pending_i = 1'b0;
    logic                    fp_flags_valid_i = 1'b0;
    logic [`FFLAGS_W-1:0]    fp_flags_i = '0;
    csr_res_t                res_o;
    logic                    wb_ready_i = 1'b1;

    logic [31:0]             lfsr = 32'h3ee4_9d11;
    logic [31:0]             cyc = '0;       // rising edges so far
    logic [31:0]             acc_cyc;        // edge count at the latest accept
    logic [`COMMIT_ID_W-1:0] cid_next = '0;
    csr_res_t                exp_q[$];
    csr_res_t                got_q[$];       // results taken by writeback

    // shadow CSR state
    logic [`XLEN-1:0]        m_mtvec = `MTVEC_RESET;
    logic [`XLEN-1:0]        m_mscratch = '0;
    logic [`XLEN-1:0]        m_mepc = '0;
    fcsr_u                   m_fcsr = '0;

    csr_subsys_top u_csr_subsys_top (
        .clk              (clk),
        .rst_i            (rst_i),
        .req_valid_i      (req_valid_i),
        .req_i            (req_i),
        .stall_o          (stall_o),
        .int_assert_i     (int_assert_i),
        .fflags_pending_i (fflags_pending_i),
        .fp_flags_valid_i (fp_flags_valid_i),
        .fp_flags_i       (fp_flags_i),
        .res_o            (res_o),
        .wb_ready_i       (wb_ready_i)
    );

    always #20 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 32'd1;

    // writeback takes a result on the edge after this
    always @(negedge clk) begin
        if (!rst_i && res_o.reg_we && wb_ready_i)
            got_q.push_back(res_o);
    end

    // fibonacci lfsr, taps 32/22/2/1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [`XLEN-1:0] model_read(input logic [`CSR_ADDR_W-1:0] addr);
        case (addr)
            `CSR_FFLAGS:   return {27'h0, m_fcsr.fld.fflags};
            `CSR_FRM:      return {29'h0, m_fcsr.fld.frm};
            `CSR_FCSR:     return m_fcsr.raw;
            `CSR_MTVEC:    return m_mtvec;
            `CSR_MSCRATCH: return m_mscratch;
            `CSR_MEPC:     return m_mepc;
            default:       return '0;
        endcase
    endfunction

    function automatic void model_write(input logic [`CSR_ADDR_W-1:0] addr,
                                        input logic [`XLEN-1:0] d);
        case (addr)
            `CSR_FFLAGS:   m_fcsr.fld.fflags = d[4:0];
            `CSR_FRM:      m_fcsr.fld.frm = d[2:0];
            `CSR_FCSR:     m_fcsr.raw = {24'h0, d[7:0]};   // only frm and fflags survive
            `CSR_MTVEC:    m_mtvec = d;
            `CSR_MSCRATCH: m_mscratch = d;
            `CSR_MEPC:     m_mepc = d;
            default: ;
        endcase
    endfunction

    function automatic csr_req_t mk_req(input csr_op_e op, input logic [`CSR_ADDR_W-1:0] addr,
                                        input logic [`XLEN-1:0] op1,
                                        input logic [`REG_ADDR_W-1:0] rd, input logic csr_we);
        csr_req_t r;
        r.op        = op;
        r.addr      = addr;
        r.op1       = op1;
        r.rd        = rd;
        r.commit_id = cid_next;
        r.csr_we    = csr_we;
        r.reg_we    = (rd != '0);   // x0 never written
        cid_next    = cid_next + 1'b1;
        return r;
    endfunction

    // plain read, CSRRS with rs1 = x0
    function automatic csr_req_t rd_req(input logic [`CSR_ADDR_W-1:0] addr,
                                        input logic [`REG_ADDR_W-1:0] rd);
        return mk_req(CSR_RS, addr, '0, rd, 1'b0);
    endfunction

    task automatic stop_failed();
        $display("TESTBENCH FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic check_res(input csr_res_t got, input csr_res_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s reg_we/rd/wdata/cid got %0b/%0d/%h/%0d",
                     $time, what, got.reg_we, got.rd, got.wdata, got.commit_id);
            $display("    expected %0b/%0d/%h/%0d",
                     exp.reg_we, exp.rd, exp.wdata, exp.commit_id);
            stop_failed();
        end
    endtask

    task automatic check_word(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            stop_failed();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
            stop_failed();
        end
    endtask

    // model step for one instruction, result queued if rd is written
    task automatic expect_req(input csr_req_t r);
        logic [`XLEN-1:0] old;
        logic [`XLEN-1:0] nxt;
        csr_res_t         e;
        old = model_read(r.addr);
        case (r.op)
            CSR_RS:  nxt = old | r.op1;
            CSR_RC:  nxt = old & ~r.op1;
            default: nxt = r.op1;
        endcase
        if (r.csr_we)
            model_write(r.addr, nxt);
        if (r.reg_we) begin
            e.reg_we    = 1'b1;
            e.rd        = r.rd;
            e.wdata     = old;
            e.commit_id = r.commit_id;
            exp_q.push_back(e);
        end
    endtask

    // returns on the accepting edge
    task automatic wait_accept();
        @(negedge clk);
        while (stall_o) begin
            @(posedge clk);
            @(negedge clk);
        end
        @(posedge clk);
        acc_cyc = cyc;
    endtask

    task automatic drive_req(input csr_req_t r);
        req_valid_i <= 1'b1;
        req_i       <= r;
        wait_accept();
    endtask

    task automatic issue(input csr_req_t r);
        expect_req(r);
        drive_req(r);
    endtask

    task automatic wait_got(input int n);
        int waited;
        waited = 0;
        while (got_q.size() < n) begin
            @(negedge clk);
            waited++;
            if (waited > 50) begin
                $display("error: %0d results expected but only %0d arrived", n, got_q.size());
                stop_failed();
            end
        end
    endtask

    // compare in order, then make sure nothing extra shows up
    task automatic drain();
        csr_res_t g;
        csr_res_t e;
        wait_got(exp_q.size());
        while (exp_q.size() > 0) begin
            g = got_q.pop_front();
            e = exp_q.pop_front();
            check_res(g, e, "writeback result");
        end
        repeat (3) @(negedge clk);
        if (got_q.size() != 0) begin
            $display("error: %0d unexpected extra results", got_q.size());
            stop_failed();
        end
    endtask

    task automatic post_flags(input logic [`FFLAGS_W-1:0] f);
        fp_flags_valid_i <= 1'b1;
        fp_flags_i       <= f;
        m_fcsr.fld.fflags = m_fcsr.fld.fflags | f;
        @(posedge clk);                           // flags land here
        fp_flags_valid_i <= 1'b0;
    endtask

    task automatic test_reset();
        csr_req_t r;
        @(negedge clk);
        check_bit(res_o.reg_we, 1'b0, "reg_we after reset");
        @(posedge clk);
        r = rd_req(`CSR_MTVEC, 5'd1);
        expect_req(r);
        wb_ready_i  <= 1'b0;                  // a stale result would stall this one
        req_valid_i <= 1'b1;
        req_i       <= r;
        @(negedge clk);
        check_bit(stall_o, 1'b0, "stall after reset");
        @(posedge clk);                       // accepted here
        wb_ready_i <= 1'b1;
        issue(rd_req(`CSR_MSCRATCH, 5'd2));
        req_valid_i <= 1'b0;
        wait_got(2);
        check_word(got_q[0].wdata, `MTVEC_RESET, "mtvec reset value");
        check_word(got_q[1].wdata, 32'h0, "mscratch reset value");
        drain();
    endtask

    task automatic test_rmw();
        logic [31:0]            bits;
        csr_op_e                op;
        logic [`CSR_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]       op1;
        logic                   csr_we;
        @(posedge clk);
        repeat (24) begin                      // back to back, few addrs so many hazards
            bits = rand_bits(2);
            addr = (bits[1:0] == 2'd0) ? `CSR_MSCRATCH :
                   (bits[1:0] == 2'd1) ? `CSR_MEPC : `CSR_MTVEC;
            bits = rand_bits(2);
            op   = (bits[1:0] == 2'd1) ? CSR_RS : (bits[1:0] == 2'd2) ? CSR_RC : CSR_RW;
            op1  = rand_bits(32);
            csr_we = 1'b1;
            bits = rand_bits(1);
            if (op != CSR_RW && bits[0]) begin // rs1 = x0 form
                op1    = '0;
                csr_we = 1'b0;
            end
            bits = rand_bits(5);
            issue(mk_req(op, addr, op1, bits[4:0], csr_we));
        end
        req_valid_i <= 1'b0;
        drain();
    endtask

    task automatic test_fcsr_views();
        @(posedge clk);
        issue(mk_req(CSR_RW, `CSR_FCSR, 32'hffff_ffa5, 5'd3, 1'b1));
        issue(rd_req(`CSR_FFLAGS, 5'd4));
        issue(rd_req(`CSR_FRM, 5'd5));
        issue(mk_req(CSR_RW, `CSR_FRM, 32'hffff_fffa, 5'd6, 1'b1));
        issue(mk_req(CSR_RS, `CSR_FFLAGS, 32'h0000_0018, 5'd7, 1'b1));
        issue(rd_req(`CSR_FCSR, 5'd8));         // upper bits read zero
        req_valid_i <= 1'b0;
        drain();
    endtask

    task automatic test_backpressure();
        csr_req_t a;
        csr_req_t b;
        @(posedge clk);
        a = mk_req(CSR_RS, `CSR_MSCRATCH, 32'h0f0f_0000, 5'd10, 1'b1);
        b = mk_req(CSR_RC, `CSR_MSCRATCH, 32'h0000_ff00, 5'd11, 1'b1);
        wb_ready_i <= 1'b0;
        issue(a);
        expect_req(b);
        req_i <= b;                            // valid stays high
        @(negedge clk);
        repeat (4) begin
            check_bit(stall_o, 1'b1, "stall under back-pressure");
            check_res(res_o, exp_q[0], "held result");
            @(negedge clk);
        end
        @(posedge clk);
        wb_ready_i <= 1'b1;
        wait_accept();
        issue(rd_req(`CSR_MSCRATCH, 5'd12));   // state readback, each write once
        issue(rd_req(`CSR_MEPC, 5'd13));
        issue(rd_req(`CSR_MTVEC, 5'd14));
        req_valid_i <= 1'b0;
        drain();
    endtask

    task automatic test_fpu_flags();
        csr_req_t r;
        @(posedge clk);
        fflags_pending_i <= 1'b1;
        r = mk_req(CSR_RW, `CSR_MSCRATCH, 32'h1234_5678, 5'd15, 1'b1);
        expect_req(r);
        req_valid_i <= 1'b1;
        req_i       <= r;
        @(negedge clk);
        check_bit(stall_o, 1'b0, "mscratch access with flags pending");
        @(posedge clk);
        r = rd_req(`CSR_FCSR, 5'd16);
        expect_req(r);
        req_i <= r;
        repeat (3) begin
            @(negedge clk);
            check_bit(stall_o, 1'b1, "fcsr access with flags pending");
        end
        @(posedge clk);
        fflags_pending_i <= 1'b0;
        wait_accept();
        req_valid_i <= 1'b0;
        post_flags(5'b00110);
        post_flags(5'b10000);
        issue(rd_req(`CSR_FFLAGS, 5'd17));
        // interrupt turns this one into a bubble
        r = mk_req(CSR_RW, `CSR_MSCRATCH, 32'hdead_beef, 5'd18, 1'b1);
        int_assert_i <= 1'b1;
        req_i        <= r;
        @(posedge clk);
        int_assert_i <= 1'b0;
        req_valid_i  <= 1'b0;
        @(negedge clk);
        check_bit(res_o.reg_we, 1'b0, "killed request reg_we");
        check_word(res_o.wdata, 32'h0, "killed request wdata");
        @(posedge clk);
        issue(rd_req(`CSR_MSCRATCH, 5'd19));   // unchanged by the kill
        req_valid_i <= 1'b0;
        drain();
    endtask

    task automatic test_mcycle();
        csr_res_t    a;
        csr_res_t    b;
        logic [31:0] c0;
        logic [31:0] c1;
        logic [31:0] v;
        @(posedge clk);
        drive_req(rd_req(`CSR_MCYCLE, 5'd20));
        c0 = acc_cyc;
        req_valid_i <= 1'b0;
        repeat (3) @(posedge clk);
        drive_req(rd_req(`CSR_MCYCLE, 5'd21));
        c1 = acc_cyc;
        req_valid_i <= 1'b0;
        wait_got(2);
        a = got_q.pop_front();
        b = got_q.pop_front();
        check_word(b.wdata - a.wdata, c1 - c0, "mcycle delta");
        v = rand_bits(32);
        @(posedge clk);
        drive_req(mk_req(CSR_RW, `CSR_MCYCLE, v, 5'd0, 1'b1));
        c0 = acc_cyc + 32'd1;                  // edge that loads mcycle
        drive_req(rd_req(`CSR_MCYCLE, 5'd22)); // taken on that edge, sees the forwarded write
        req_valid_i <= 1'b0;
        repeat (4) @(posedge clk);
        drive_req(rd_req(`CSR_MCYCLE, 5'd23));
        req_valid_i <= 1'b0;
        wait_got(2);
        a = got_q.pop_front();
        b = got_q.pop_front();
        check_word(a.wdata, v, "mcycle read after write");
        // k edges after the loading edge the read returns v + k - 1
        check_word(b.wdata, v + (acc_cyc - c0) - 32'd1, "mcycle later read");
    endtask

    initial begin
        repeat (5) @(posedge clk);
        rst_i <= 1'b0;
        test_reset();
        test_rmw();
        test_fcsr_views();
        test_backpressure();
        test_fpu_flags();
        test_mcycle();
        $display("TESTBENCH PASSED");
        $finish;
    end

    // generous bound per test
    initial begin
        #(NUM_TESTS * 200 * 40);
        $display("timeout: the tests did not finish in the allowed time");
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule
